// File: src/alu_pkg.sv
//////////////////////////////
// shared types for the chunk-serial alu
// operand word width and word type
// request, flag and result structs
// per-stage in-flight item state
//////////////////////////////

package alu_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // operand word width, every struct below depends on it
    localparam int DATA_W = 16;

    // one operand, or one arithmetic result
    typedef logic [DATA_W-1:0] word_t;

    //////////////////////////////
    // request and result
    //////////////////////////////

    // one request as it enters the pipe
    // a is the main operand, b feeds add/sub, c feeds the compare
    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
    } alu_req_t;

    // single-bit results
    typedef struct packed {
        logic red_and;
        logic red_or;
        logic red_xor;
        logic eq;
        logic neq;
    } alu_flags_t;

    // one complete answer
    typedef struct packed {
        word_t      sum;
        word_t      diff;
        alu_flags_t flags;
    } alu_result_t;

    //////////////////////////////
    // in-flight item
    //////////////////////////////

    // state handed from one stage to the next
    // operands travel along so a new request can enter every cycle
    // sum and diff are filled in from the lowest chunk upward
    typedef struct packed {
        logic     valid;
        alu_req_t req;
        word_t    sum;
        word_t    diff;
        // carry and borrow out of the chunk just processed
        logic     carry;
        logic     borrow;
        // partial flags over the chunks seen so far
        logic     acc_and;
        logic     acc_or;
        logic     acc_xor;
        logic     acc_eq;
    } stage_state_t;

endpackage

// File: src/chunk_alu_stage.sv
//////////////////////////////
// one stage of the chunk-serial alu pipeline
// adds and subtracts one chunk with carry/borrow in
// folds one chunk into the reduction and compare flags
// registers the in-flight item on advance
//////////////////////////////

module chunk_alu_stage #(
    parameter int CHUNK_W   = 4,
    parameter int STAGE_IDX = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  advance,
    input  alu_pkg::stage_state_t prev,
    output alu_pkg::stage_state_t next
);

    //////////////////////////////
    // local types and constants
    //////////////////////////////

    // lowest bit of the chunk this stage owns
    localparam int CHUNK_LO = STAGE_IDX * CHUNK_W;

    // one operand chunk
    typedef logic [CHUNK_W-1:0] chunk_t;
    // chunk with the carry or borrow bit on top
    typedef logic [CHUNK_W:0] chunk_ext_t;

    // operand chunks picked out of the travelling request
    chunk_t a_chunk;
    chunk_t b_chunk;
    chunk_t c_chunk;

    // incoming chain values or the neutral start values for stage 0
    logic carry_in;
    logic borrow_in;
    logic and_in;
    logic or_in;
    logic xor_in;
    logic eq_in;

    // chunk results with carry/borrow out in the top bit
    chunk_ext_t sum_ext;
    chunk_ext_t diff_ext;

    // next register value and the register itself
    alu_pkg::stage_state_t state_d;
    alu_pkg::stage_state_t state_q;

    //////////////////////////////
    // operand select
    //////////////////////////////

    assign a_chunk = prev.req.a[CHUNK_LO +: CHUNK_W];
    assign b_chunk = prev.req.b[CHUNK_LO +: CHUNK_W];
    assign c_chunk = prev.req.c[CHUNK_LO +: CHUNK_W];

    //////////////////////////////
    // chain inputs
    //////////////////////////////

    if (STAGE_IDX == 0) begin : g_first
        // bottom chunk starts from the neutral values
        // whatever the predecessor state holds here is ignored
        assign carry_in  = 1'b0;
        assign borrow_in = 1'b0;
        assign and_in    = 1'b1;
        assign or_in     = 1'b0;
        assign xor_in    = 1'b0;
        assign eq_in     = 1'b1;
    end else begin : g_chain
        // continue from the chunk below
        assign carry_in  = prev.carry;
        assign borrow_in = prev.borrow;
        assign and_in    = prev.acc_and;
        assign or_in     = prev.acc_or;
        assign xor_in    = prev.acc_xor;
        assign eq_in     = prev.acc_eq;
    end

    //////////////////////////////
    // chunk arithmetic
    //////////////////////////////

    // top bit of sum_ext is the carry into the next chunk
    assign sum_ext = {1'b0, a_chunk} + {1'b0, b_chunk} + chunk_ext_t'(carry_in);

    // top bit of diff_ext goes high when the chunk underflows
    // which is exactly the borrow into the next chunk
    assign diff_ext = {1'b0, a_chunk} - {1'b0, b_chunk} - chunk_ext_t'(borrow_in);

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        // operands, valid and the other chunks pass straight through
        state_d = prev;

        // drop this chunk's results into place
        state_d.sum[CHUNK_LO +: CHUNK_W]  = sum_ext[CHUNK_W-1:0];
        state_d.diff[CHUNK_LO +: CHUNK_W] = diff_ext[CHUNK_W-1:0];
        state_d.carry                     = sum_ext[CHUNK_W];
        state_d.borrow                    = diff_ext[CHUNK_W];

        // fold this chunk into the running flags
        state_d.acc_and = and_in & (&a_chunk);
        state_d.acc_or  = or_in | (|a_chunk);
        state_d.acc_xor = xor_in ^ (^a_chunk);
        state_d.acc_eq  = eq_in & (a_chunk == c_chunk);
    end

    //////////////////////////////
    // stage register
    //////////////////////////////

    // only valid is cleared on reset
    // the whole item holds while the pipe is stalled
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q.valid <= 1'b0;
        end else if (advance) begin
            state_q <= state_d;
        end
    end

    assign next = state_q;

endmodule

// File: src/chunk_alu_top.sv
//////////////////////////////
// top level of the chunk-serial alu
// valid/ready handshake and pipe advance
// generate chain of chunk stages
// result mapping from the last stage
//////////////////////////////

module chunk_alu_top #(
    parameter int CHUNK_W = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    // request side
    input  logic                 in_valid,
    output logic                 in_ready,
    input  alu_pkg::alu_req_t    in_req,
    // result side
    output logic                 out_valid,
    input  logic                 out_ready,
    output alu_pkg::alu_result_t out_result
);

    // one stage per chunk, also the latency in cycles
    localparam int NUM_STAGES = alu_pkg::DATA_W / CHUNK_W;

    // chunk width has to split the word evenly
    if (alu_pkg::DATA_W % CHUNK_W != 0) begin : g_bad_chunk
        $error("chunk_alu_top: CHUNK_W %0d does not divide the word", CHUNK_W);
    end

    // pipe-wide enable
    logic advance;

    // chain[0] feeds stage 0, chain[NUM_STAGES] is the last register
    alu_pkg::stage_state_t chain [NUM_STAGES+1];

    // the item at the end of the pipe
    alu_pkg::stage_state_t last;

    //////////////////////////////
    // handshake
    //////////////////////////////

    // the pipe moves unless a finished result is waiting to be taken
    // bubbles are not squeezed out
    assign advance  = ~out_valid | out_ready;
    assign in_ready = advance;

    //////////////////////////////
    // stage 0 input
    //////////////////////////////

    // only valid and req matter here, stage 0 uses neutral chain values
    always_comb begin
        chain[0]       = '0;
        chain[0].valid = in_valid;
        chain[0].req   = in_req;
    end

    //////////////////////////////
    // stage chain
    //////////////////////////////

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        chunk_alu_stage #(
            .CHUNK_W   (CHUNK_W),
            .STAGE_IDX (i)
        ) u_stage (
            .clk     (clk),
            .rst     (rst),
            .advance (advance),
            .prev    (chain[i]),
            .next    (chain[i+1])
        );
    end

    //////////////////////////////
    // result
    //////////////////////////////

    assign last      = chain[NUM_STAGES];
    assign out_valid = last.valid;

    always_comb begin
        out_result.sum           = last.sum;
        out_result.diff          = last.diff;
        out_result.flags.red_and = last.acc_and;
        out_result.flags.red_or  = last.acc_or;
        out_result.flags.red_xor = last.acc_xor;
        out_result.flags.eq      = last.acc_eq;
        // not-equal is just the inverse of equal
        out_result.flags.neq     = ~last.acc_eq;
    end

endmodule

// File: verif/chunk_alu_properties.sv
//////////////////////////////
// concurrent checks on the alu top level
// output hold under back-pressure
// pipe state right after reset
//////////////////////////////

module chunk_alu_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 out_valid,
    input logic                 out_ready,
    input alu_pkg::alu_result_t out_result
);

    // a result waiting for out_ready must not move
    a_result_stable : assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_result))
        else $error("out_result changed while stalled");

    // nor may it vanish before it is taken
    a_valid_held : assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before the result was taken");

    // pipe is empty right after reset
    a_reset_empty : assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

endmodule

bind chunk_alu_top chunk_alu_properties u_chunk_alu_properties (
    .clk        (clk),
    .rst        (rst),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

// File: verif/tb_clk_gen.sv
//////////////////////////////
// testbench clock and reset
// period 100, reset high for 5 cycles
//////////////////////////////

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset drops on the 5th rising edge
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verif/tb_chunk_alu.sv
//////////////////////////////
// testbench for the chunk-serial alu
// reads requests and expected results from a vector file
// back-to-back pass, then a pass with random back-pressure
// in-order result checks and a cycle timeout
//////////////////////////////

module tb_chunk_alu;

    localparam int CHUNK_W     = 4;
    localparam int NUM_STAGES  = alu_pkg::DATA_W / CHUNK_W;
    localparam int NUM_VEC     = 16;
    // every vector goes through once per pass
    localparam int NUM_PASSES  = 2;
    localparam int CYCLE_LIMIT = 10 * NUM_VEC * NUM_PASSES * (NUM_STAGES + 1);

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    alu_pkg::alu_req_t    in_req;
    logic                 out_valid;
    logic                 out_ready;
    alu_pkg::alu_result_t out_result;

    // six hex words per vector in the order a b c sum diff flags
    alu_pkg::word_t vec_mem [6*NUM_VEC];

    // expected answers and their vector numbers in acceptance order
    alu_pkg::alu_result_t exp_q [$];
    int                   idx_q [$];

    logic        bp_on = 1'b0;
    int          check_errors = 0;
    int          other_errors = 0;
    int          results_seen = 0;
    int          cycle_count = 0;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    chunk_alu_top #(
        .CHUNK_W (CHUNK_W)
    ) u_chunk_alu_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_word(input string name, input alu_pkg::word_t expected,
                              input alu_pkg::word_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_flags(input string name, input alu_pkg::alu_flags_t expected,
                               input alu_pkg::alu_flags_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
            check_errors++;
        end
    endtask

    // expected answer of vector n as read from the file
    function automatic alu_pkg::alu_result_t vec_result(input int n);
        alu_pkg::alu_result_t r;
        r.sum   = vec_mem[6*n+3];
        r.diff  = vec_mem[6*n+4];
        r.flags = alu_pkg::alu_flags_t'(vec_mem[6*n+5][4:0]);
        return r;
    endfunction

    // present vector n and hold it until the edge that takes it
    task automatic send_request(input int n);
        int waits;
        waits = 0;
        in_valid <= 1'b1;
        in_req.a <= vec_mem[6*n];
        in_req.b <= vec_mem[6*n+1];
        in_req.c <= vec_mem[6*n+2];
        @(posedge clk);
        while (!in_ready) begin
            waits++;
            @(posedge clk);
        end
        exp_q.push_back(vec_result(n));
        idx_q.push_back(n);
        if (!bp_on && waits != 0) begin
            $display("request %0d was stalled although out_ready was high", n);
            other_errors++;
        end
    endtask

    //////////////////////////////
    // output side
    //////////////////////////////

    // low about one cycle in three during the back-pressure pass
    initial begin
        void'($urandom(96384));
        out_ready = 1'b1;
        forever begin
            @(posedge clk);
            if (bp_on) begin
                out_ready <= ($urandom % 3) != 0;
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin : monitor
        alu_pkg::alu_result_t exp_r;
        string                name;
        if (!rst && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("a result came out with no request pending");
                other_errors++;
            end else begin
                exp_r = exp_q.pop_front();
                name  = $sformatf("vector %0d", idx_q.pop_front());
                check_word({name, " sum"}, exp_r.sum, out_result.sum);
                check_word({name, " diff"}, exp_r.diff, out_result.diff);
                check_flags({name, " flags"}, exp_r.flags, out_result.flags);
            end
            results_seen++;
        end
        // the back-to-back pass leaves no gap once the pipe fills
        if (!rst && !bp_on && !out_valid && results_seen > 0 && results_seen < NUM_VEC) begin
            $display("out_valid dropped during the back-to-back pass");
            other_errors++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d results missing", cycle_count,
                     exp_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        in_valid  = 1'b0;
        in_req    = '0;
        $readmemh("verif/alu_input_vectors.txt", vec_mem);

        @(posedge clk);
        while (rst) @(posedge clk);
        // idle pipe right after reset
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("after reset out_valid is not low or in_ready is not high");
            other_errors++;
        end

        for (int pass = 0; pass < NUM_PASSES; pass++) begin
            for (int n = 0; n < NUM_VEC; n++) begin
                send_request(n);
            end
            in_valid <= 1'b0;
            while (exp_q.size() != 0) @(posedge clk);
            bp_on <= 1'b1;
        end

        @(posedge clk);
        if (results_seen != NUM_VEC * NUM_PASSES) begin
            $display("expected %0d results but saw %0d", NUM_VEC * NUM_PASSES, results_seen);
            other_errors++;
        end
        $display("value errors: %0d, other errors: %0d", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/alu_pkg.sv
src/chunk_alu_stage.sv
src/chunk_alu_top.sv
verif/chunk_alu_properties.sv
verif/tb_clk_gen.sv
verif/tb_chunk_alu.sv

// File: run.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_chunk_alu -f vlog.f \
    && ./obj_dir/Vtb_chunk_alu > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "TB FAILED" sim.log \
    && echo "run.sh: simulation ok" \
    || { cat sim.log 2>/dev/null; echo "run.sh: simulation failed"; exit 1; }

// File: verif/alu_input_vectors.txt
// columns: a b c expected_sum expected_diff expected_flags
// flag bits 4..0 are red_and red_or red_xor eq neq
FFFF 0001 FFFF 0000 FFFE 1A
0000 0001 0000 0001 FFFF 02
0FFF 0001 0FFE 1000 0FFE 09
0001 0000 0001 0001 0001 0E
0010 0010 1010 0020 0000 0D
0100 0200 0100 0300 FF00 0E
8000 8000 8000 0000 0000 0E
1234 5678 1234 68AC BBBC 0E
ABCD 1111 ABCC BCDE 9ABC 09
FFF0 0010 FFF0 0000 FFE0 0A
00FF 0F01 00FF 1000 F1FE 0A
7FFF FFFF 7FFF 7FFE 8000 0E
F00F 0FF1 F00F 0000 E01E 0A
5555 AAAA 5555 FFFF AAAB 0A
8421 0001 8421 8422 8420 0A
0800 0801 0800 1001 FFFF 0E
